// File: rtl/rapcore_pkg.sv
`default_nettype none

package rapcore_pkg;

  // SPI framing
  localparam int frame_bits = 64;

  // Command opcodes, anything else is ignored
  localparam logic [7:0] op_write_cfg = 8'h01;
  localparam logic [7:0] op_move      = 8'h02;

  // Configuration register map
  localparam logic [7:0] reg_microsteps = 8'h01;
  localparam logic [7:0] reg_current    = 8'h02;
  localparam logic [7:0] reg_enable     = 8'h03;

  // Move command fields
  localparam int move_bits = 24;
  localparam logic [move_bits-1:0] min_period = 2;  // Keeps step a single-cycle pulse

  localparam int microstep_bits = 8;  // 256 positions per electrical cycle
  localparam int pwm_bits       = 8;
  localparam int enc_bits       = 32;

  // Quarter-wave sine, sampled at bin centres so both halves mirror exactly
  localparam int sine_entries = 64;
  localparam logic [microstep_bits-1:0] quarter_turn = microstep_bits'(sine_entries);
  localparam logic [pwm_bits-1:0] sine_quarter [sine_entries] = '{
    8'd3,   8'd9,   8'd16,  8'd22,  8'd28,  8'd34,  8'd41,  8'd47,
    8'd53,  8'd59,  8'd65,  8'd71,  8'd77,  8'd83,  8'd89,  8'd95,
    8'd100, 8'd106, 8'd112, 8'd117, 8'd123, 8'd128, 8'd134, 8'd139,
    8'd144, 8'd149, 8'd154, 8'd159, 8'd164, 8'd169, 8'd174, 8'd178,
    8'd183, 8'd187, 8'd191, 8'd195, 8'd199, 8'd203, 8'd207, 8'd210,
    8'd214, 8'd217, 8'd220, 8'd223, 8'd226, 8'd229, 8'd232, 8'd234,
    8'd237, 8'd239, 8'd241, 8'd243, 8'd245, 8'd247, 8'd248, 8'd249,
    8'd251, 8'd252, 8'd253, 8'd253, 8'd254, 8'd255, 8'd255, 8'd255
  };

  // One received frame, viewed by opcode
  typedef union packed {
    struct packed {
      logic [7:0]  opcode;
      logic [7:0]  addr;
      logic [15:0] rsvd;
      logic [31:0] data;
    } cfg;
    struct packed {
      logic [7:0]           opcode;
      logic                 dir;   // 1 is forward
      logic [6:0]           rsvd;
      logic [move_bits-1:0] steps;
      logic [move_bits-1:0] period;
    } move;
  } cmd_word_t;

endpackage

`default_nettype wire

// File: rtl/spi_command_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module spi_command_fsm (
  input  logic                                   CLK,
  input  logic                                   resetn,
  input  logic                                   sck,
  input  logic                                   cs,
  input  logic                                   copi,
  output logic                                   cipo,
  input  logic signed [rapcore_pkg::enc_bits-1:0] enc_count,
  input  logic                                   enc_fault,
  input  logic                                   move_busy,
  output logic                                   move_start,
  output logic                                   move_dir,
  output logic [rapcore_pkg::move_bits-1:0]      move_steps,
  output logic [rapcore_pkg::move_bits-1:0]      move_period,
  output logic [2:0]                             microsteps,
  output logic [7:0]                             current,
  output logic                                   enable
);

  logic [2:0] sck_r;   // Two sync stages plus edge history
  logic [2:0] cs_r;
  logic [1:0] copi_r;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_fall;
  logic       cs_rise;
  logic       selected;

  logic [rapcore_pkg::frame_bits-1:0]      shreg;
  logic [rapcore_pkg::frame_bits-1:0]      status;
  logic [$clog2(rapcore_pkg::frame_bits):0] bit_cnt;

  rapcore_pkg::cmd_word_t frame_q;
  logic frame_ok;
  logic cfg_hit;
  logic move_hit;
  logic wr_microsteps;
  logic wr_current;
  logic wr_enable;
  logic move_req;

  assign sck_rise = sck_r[1] & ~sck_r[2];
  assign sck_fall = ~sck_r[1] & sck_r[2];
  assign cs_fall  = ~cs_r[1] & cs_r[2];
  assign cs_rise  = cs_r[1] & ~cs_r[2];
  assign selected = ~cs_r[1];

  // Count, fault, busy, then zero fill
  assign status = {enc_count, enc_fault, move_busy,
                   {(rapcore_pkg::frame_bits - rapcore_pkg::enc_bits - 2){1'b0}}};

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_r  <= 3'b000;
      cs_r   <= 3'b111;  // Idle deselected
      copi_r <= 2'b00;
    end else begin
      sck_r  <= {sck_r[1:0], sck};
      cs_r   <= {cs_r[1:0], cs};
      copi_r <= {copi_r[0], copi};
    end
  end

  // Shift register, no reset needed
  always_ff @(posedge CLK) begin
    if (cs_fall) begin
      shreg <= status;
    end else if (sck_rise && selected) begin
      shreg <= {shreg[rapcore_pkg::frame_bits-2:0], copi_r[1]};
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      bit_cnt <= '0;
      cipo    <= 1'b0;
    end else begin
      if (cs_fall) begin
        bit_cnt <= '0;
        cipo    <= status[rapcore_pkg::frame_bits-1];  // MSB ready before first rise
      end else begin
        if (sck_rise && selected && bit_cnt != '1) begin
          bit_cnt <= bit_cnt + 1'b1;  // Saturates so overlong frames stay invalid
        end
        if (sck_fall && selected) begin
          cipo <= shreg[rapcore_pkg::frame_bits-1];
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (cs_rise) begin
      frame_q <= shreg;
    end
  end

  // Decode pipeline: length check, opcode, address, write
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      frame_ok      <= 1'b0;
      cfg_hit       <= 1'b0;
      move_hit      <= 1'b0;
      wr_microsteps <= 1'b0;
      wr_current    <= 1'b0;
      wr_enable     <= 1'b0;
      move_req      <= 1'b0;
    end else begin
      frame_ok      <= cs_rise && (bit_cnt == rapcore_pkg::frame_bits);
      cfg_hit       <= frame_ok && (frame_q.cfg.opcode == rapcore_pkg::op_write_cfg);
      move_hit      <= frame_ok && (frame_q.move.opcode == rapcore_pkg::op_move);
      wr_microsteps <= cfg_hit && (frame_q.cfg.addr == rapcore_pkg::reg_microsteps);
      wr_current    <= cfg_hit && (frame_q.cfg.addr == rapcore_pkg::reg_current);
      wr_enable     <= cfg_hit && (frame_q.cfg.addr == rapcore_pkg::reg_enable);
      move_req      <= move_hit;
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      microsteps <= 3'd0;
      current    <= 8'd0;
      enable     <= 1'b0;
      move_start <= 1'b0;
    end else begin
      move_start <= move_req;  // Dropped downstream if a move is running
      if (wr_microsteps) microsteps <= frame_q.cfg.data[2:0];
      if (wr_current)    current    <= frame_q.cfg.data[7:0];
      if (wr_enable)     enable     <= frame_q.cfg.data[0];
    end
  end

  // Move parameters travel with move_start
  always_ff @(posedge CLK) begin
    if (move_req) begin
      move_dir    <= frame_q.move.dir;
      move_steps  <= frame_q.move.steps;
      move_period <= frame_q.move.period;
    end
  end

endmodule

`default_nettype wire

// File: rtl/step_pulse_gen.sv
`timescale 1ns/1ps
`default_nettype none

module step_pulse_gen (
  input  logic                              CLK,
  input  logic                              resetn,
  input  logic                              move_start,
  input  logic                              move_dir,
  input  logic [rapcore_pkg::move_bits-1:0] move_steps,
  input  logic [rapcore_pkg::move_bits-1:0] move_period,
  output logic                              step,
  output logic                              dir,
  output logic                              move_done,
  output logic                              move_busy
);

  logic                              busy;
  logic [rapcore_pkg::move_bits-1:0] remaining;
  logic [rapcore_pkg::move_bits-1:0] timer;      // Cycles left to the next strobe
  logic [rapcore_pkg::move_bits-1:0] period_q;
  logic [rapcore_pkg::move_bits-1:0] period_min;

  assign period_min = (move_period < rapcore_pkg::min_period) ? rapcore_pkg::min_period
                                                              : move_period;
  assign move_busy  = busy;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      busy      <= 1'b0;
      step      <= 1'b0;
      dir       <= 1'b0;
      move_done <= 1'b0;
      remaining <= '0;
      timer     <= '0;
      period_q  <= '0;
    end else begin
      step      <= 1'b0;
      move_done <= 1'b0;
      if (move_start && !busy) begin
        dir <= move_dir;
        if (move_steps == '0) begin
          move_done <= 1'b1;  // Empty move finishes at once
        end else begin
          busy      <= 1'b1;
          remaining <= move_steps;
          timer     <= period_min - 1'b1;  // First strobe lands period cycles out
          period_q  <= period_min;
        end
      end else if (busy) begin
        if (timer == 1) begin
          step      <= 1'b1;
          timer     <= period_q;
          remaining <= remaining - 1'b1;
          if (remaining == 1) begin
            busy      <= 1'b0;
            move_done <= 1'b1;  // Same cycle as the last strobe
          end
        end else begin
          timer <= timer - 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/phase_driver.sv
`timescale 1ns/1ps
`default_nettype none

module phase_driver (
  input  logic       CLK,
  input  logic       resetn,
  input  logic       step,
  input  logic       dir,
  input  logic       enable,
  input  logic [2:0] microsteps,
  input  logic [7:0] current,
  output logic       phase_a1,
  output logic       phase_a2,
  output logic       phase_b1,
  output logic       phase_b2
);

  logic [rapcore_pkg::microstep_bits-1:0] pos;
  logic [rapcore_pkg::microstep_bits-1:0] cos_pos;
  logic [rapcore_pkg::microstep_bits:0]   step_size;
  logic [2:0]                             shift;
  logic [rapcore_pkg::pwm_bits-1:0]       pwm_cnt;
  logic [rapcore_pkg::pwm_bits-1:0]       mag_a;
  logic [rapcore_pkg::pwm_bits-1:0]       mag_b;
  logic [rapcore_pkg::pwm_bits-1:0]       duty_a;
  logic [rapcore_pkg::pwm_bits-1:0]       duty_b;
  logic [2*rapcore_pkg::pwm_bits-1:0]     prod_a;
  logic [2*rapcore_pkg::pwm_bits-1:0]     prod_b;
  logic                                   neg_a;
  logic                                   neg_b;

  // Mirror the index in odd quadrants
  function automatic logic [rapcore_pkg::pwm_bits-1:0] sine_mag(
    input logic [rapcore_pkg::microstep_bits-1:0] p
  );
    logic [$clog2(rapcore_pkg::sine_entries)-1:0] idx;
    idx = p[rapcore_pkg::microstep_bits-2] ? ~p[rapcore_pkg::microstep_bits-3:0]
                                           : p[rapcore_pkg::microstep_bits-3:0];
    return rapcore_pkg::sine_quarter[idx];
  endfunction

  assign shift     = (microsteps > 3'd6) ? 3'd6 : microsteps;
  assign step_size = {1'b1, {rapcore_pkg::microstep_bits{1'b0}}} >> shift;
  assign cos_pos   = pos + rapcore_pkg::quarter_turn;  // cos(x) = sin(x + 90)
  assign mag_a     = sine_mag(cos_pos);
  assign mag_b     = sine_mag(pos);
  assign prod_a    = mag_a * current;
  assign prod_b    = mag_b * current;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      pos <= '0;
    end else if (step) begin
      pos <= dir ? pos + step_size[rapcore_pkg::microstep_bits-1:0]
                 : pos - step_size[rapcore_pkg::microstep_bits-1:0];
    end
  end

  // Duty and polarity only change at PWM wrap
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      pwm_cnt <= '0;
      duty_a  <= '0;
      duty_b  <= '0;
      neg_a   <= 1'b0;
      neg_b   <= 1'b0;
    end else begin
      pwm_cnt <= pwm_cnt + 1'b1;
      if (pwm_cnt == '1) begin
        duty_a <= prod_a[2*rapcore_pkg::pwm_bits-1:rapcore_pkg::pwm_bits];
        duty_b <= prod_b[2*rapcore_pkg::pwm_bits-1:rapcore_pkg::pwm_bits];
        neg_a  <= cos_pos[rapcore_pkg::microstep_bits-1];
        neg_b  <= pos[rapcore_pkg::microstep_bits-1];
      end
    end
  end

  // One side of each bridge switches, the other stays low
  assign phase_a1 = enable & ~neg_a & (pwm_cnt < duty_a);
  assign phase_a2 = enable &  neg_a & (pwm_cnt < duty_a);
  assign phase_b1 = enable & ~neg_b & (pwm_cnt < duty_b);
  assign phase_b2 = enable &  neg_b & (pwm_cnt < duty_b);

endmodule

`default_nettype wire

// File: rtl/quad_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module quad_encoder (
  input  logic                                   CLK,
  input  logic                                   resetn,
  input  logic                                   enc_a,
  input  logic                                   enc_b,
  output logic signed [rapcore_pkg::enc_bits-1:0] enc_count,
  output logic                                   enc_fault
);

  logic [1:0] a_r;
  logic [1:0] b_r;
  logic [1:0] ab_now;
  logic [1:0] ab_prev;

  assign ab_now = {a_r[1], b_r[1]};

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      a_r     <= 2'b00;
      b_r     <= 2'b00;
      ab_prev <= 2'b00;
    end else begin
      a_r     <= {a_r[0], enc_a};
      b_r     <= {b_r[0], enc_b};
      ab_prev <= ab_now;
    end
  end

  // x4 decode with A leading B counting up
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      enc_count <= '0;
      enc_fault <= 1'b0;
    end else begin
      case ({ab_prev, ab_now})
        4'b0010, 4'b1011, 4'b1101, 4'b0100: begin
          enc_count <= enc_count + 1;
        end
        4'b0001, 4'b0111, 4'b1110, 4'b1000: begin
          enc_count <= enc_count - 1;
        end
        4'b0011, 4'b1100, 4'b0110, 4'b1001: begin
          enc_fault <= 1'b1;  // Lost step stays flagged until reset
        end
        default: begin
          enc_count <= enc_count;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/rapcore.sv
`timescale 1ns/1ps
`default_nettype none

module rapcore (
  input  logic CLK,
  input  logic resetn,
  input  logic sck,
  input  logic cs,
  input  logic copi,
  output logic cipo,
  input  logic enc_a,
  input  logic enc_b,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2,
  output logic step,
  output logic dir,
  output logic move_done
);

  logic                                   move_start;
  logic                                   move_dir;
  logic [rapcore_pkg::move_bits-1:0]      move_steps;
  logic [rapcore_pkg::move_bits-1:0]      move_period;
  logic                                   move_busy;
  logic [2:0]                             microsteps;
  logic [7:0]                             current;
  logic                                   enable;
  logic signed [rapcore_pkg::enc_bits-1:0] enc_count;
  logic                                   enc_fault;

  // Host command port
  spi_command_fsm spi_fsm (
    .CLK         (CLK),
    .resetn      (resetn),
    .sck         (sck),
    .cs          (cs),
    .copi        (copi),
    .cipo        (cipo),
    .enc_count   (enc_count),
    .enc_fault   (enc_fault),
    .move_busy   (move_busy),
    .move_start  (move_start),
    .move_dir    (move_dir),
    .move_steps  (move_steps),
    .move_period (move_period),
    .microsteps  (microsteps),
    .current     (current),
    .enable      (enable)
  );

  step_pulse_gen stepper (
    .CLK         (CLK),
    .resetn      (resetn),
    .move_start  (move_start),
    .move_dir    (move_dir),
    .move_steps  (move_steps),
    .move_period (move_period),
    .step        (step),
    .dir         (dir),
    .move_done   (move_done),
    .move_busy   (move_busy)
  );

  phase_driver phases (
    .CLK        (CLK),
    .resetn     (resetn),
    .step       (step),
    .dir        (dir),
    .enable     (enable),
    .microsteps (microsteps),
    .current    (current),
    .phase_a1   (phase_a1),
    .phase_a2   (phase_a2),
    .phase_b1   (phase_b1),
    .phase_b2   (phase_b2)
  );

  quad_encoder encoder (
    .CLK       (CLK),
    .resetn    (resetn),
    .enc_a     (enc_a),
    .enc_b     (enc_b),
    .enc_count (enc_count),
    .enc_fault (enc_fault)
  );

endmodule

`default_nettype wire

// File: test/rapcore_chk.sv
`timescale 1ns/1ps
`default_nettype none

module rapcore_chk (
  input logic CLK,
  input logic resetn,
  input logic phase_a1,
  input logic phase_a2,
  input logic phase_b1,
  input logic phase_b2,
  input logic step,
  input logic move_done,
  input logic move_start,
  input logic enable
);

  int assert_errors = 0;  // Read by the testbench for its verdict

  // Shoot-through on either bridge
  bridge_a_exclusive: assert property (@(posedge CLK) disable iff (!resetn)
    !(phase_a1 && phase_a2))
    else begin assert_errors++; $error("phase_a1 and phase_a2 high together"); end

  bridge_b_exclusive: assert property (@(posedge CLK) disable iff (!resetn)
    !(phase_b1 && phase_b2))
    else begin assert_errors++; $error("phase_b1 and phase_b2 high together"); end

  step_one_cycle: assert property (@(posedge CLK) disable iff (!resetn) step |=> !step)
    else begin assert_errors++; $error("step held high longer than one cycle"); end

  silent_when_disabled: assert property (@(posedge CLK) disable iff (!resetn)
    !enable |-> !(phase_a1 || phase_a2 || phase_b1 || phase_b2))
    else begin assert_errors++; $error("phase output active while disabled"); end

  // Last strobe, or an empty move
  done_placement: assert property (@(posedge CLK) disable iff (!resetn)
    move_done |-> (step || $past(move_start)))
    else begin assert_errors++; $error("move_done outside a step cycle"); end

endmodule

`default_nettype wire

// File: test/rapcore_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rapcore_tb;

  logic CLK = 1'b0;
  logic resetn;
  logic sck;
  logic cs;
  logic copi;
  logic enc_a;
  logic enc_b;
  logic cipo;
  logic phase_a1;
  logic phase_a2;
  logic phase_b1;
  logic phase_b2;
  logic step;
  logic dir;
  logic move_done;

  int unsigned rng_state = 76627;
  int errors = 0;
  int cyc = 0;
  int step_total = 0;
  int done_total = 0;
  int last_step_cyc = 0;
  int exp_period = 0;
  int exp_shift = 0;         // Mirrors the microsteps register
  int watchdog_cycles = 0;
  logic exp_dir = 1'b1;
  logic [7:0] exp_pos = 8'd0;
  logic [1:0] enc_idx = 2'd0;  // Position in the Gray cycle
  logic [63:0] rx;

  rapcore dut (.*);

  bind rapcore rapcore_chk checks (
    .CLK(CLK), .resetn(resetn), .phase_a1(phase_a1), .phase_a2(phase_a2),
    .phase_b1(phase_b1), .phase_b2(phase_b2), .step(step), .move_done(move_done),
    .move_start(move_start), .enable(enable)
  );

  always #5 CLK = ~CLK;

  function automatic int unsigned lcg_range(input int unsigned span);
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return (rng_state >> 16) % span;
  endfunction

  task automatic check_val(input string name, input logic signed [63:0] expected,
                           input logic signed [63:0] actual);
    if (expected !== actual) begin
      errors = errors + 1;
      $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge CLK);
  endtask

  // Step bookkeeping and expected microstep position
  always @(negedge CLK) begin
    cyc = cyc + 1;
    if (resetn && step) begin
      check_val("dir", exp_dir, dir);
      if (step_total > 0) check_val("step spacing", exp_period, cyc - last_step_cyc);
      last_step_cyc = cyc;
      step_total = step_total + 1;
      exp_pos = exp_dir ? exp_pos + (256 >> exp_shift) : exp_pos - (256 >> exp_shift);
    end
    if (resetn && move_done) done_total = done_total + 1;
  end

  // Mode 0, MSB first, 8 CLK per bit
  task automatic spi_frame(input logic [63:0] tx, output logic [63:0] rxw);
    @(posedge CLK) cs <= 1'b0;
    wait_cycles(4);
    for (int i = 63; i >= 0; i--) begin
      sck  <= 1'b0;
      copi <= tx[i];
      wait_cycles(3);
      @(negedge CLK) rxw[i] = cipo;
      @(posedge CLK) sck <= 1'b1;
      wait_cycles(4);
    end
    sck <= 1'b0;
    wait_cycles(4);
    cs <= 1'b1;
    wait_cycles(8);  // Decode latency
  endtask

  function automatic logic [63:0] move_word(input logic d, input int n, input int p);
    return {rapcore_pkg::op_move, d, 7'd0, 24'(n), 24'(p)};
  endfunction

  function automatic logic [63:0] cfg_word(input logic [7:0] addr, input logic [31:0] data);
    return {rapcore_pkg::op_write_cfg, addr, 16'd0, data};
  endfunction

  task automatic start_tracking(input logic d, input int p);
    @(posedge CLK);
    step_total = 0;
    done_total = 0;
    exp_dir    = d;
    exp_period = p;
  endtask

  task automatic wait_done(input int limit);
    int n;
    n = 0;
    while (done_total < 1 && n < limit) begin
      @(posedge CLK);
      n++;
    end
    if (done_total < 1) begin
      errors = errors + 1;
      $display("Timed out at %0t waiting for move_done", $time);
    end
  endtask

  task automatic run_move(input logic d, input int n, input int p);
    logic [63:0] r;
    start_tracking(d, p);
    spi_frame(move_word(d, n, p), r);
    wait_done(n * p + 100);
    wait_cycles(p + 4);
    check_val("step count", n, step_total);
    check_val("move_done count", 1, done_total);
  endtask

  // Polarity from the sign of cos and sin at the bin centre of exp_pos
  task automatic check_phases(input logic on);
    logic [3:0] seen;
    logic a_neg;
    logic b_neg;
    seen  = 4'b0000;
    a_neg = (exp_pos >= 64) && (exp_pos < 192);
    b_neg = (exp_pos >= 128);
    wait_cycles(260);  // Let the PWM wrap latch the new duty
    repeat (256) begin
      @(negedge CLK);
      seen = seen | {phase_a1, phase_a2, phase_b1, phase_b2};
    end
    check_val("phase_a1", on & ~a_neg, seen[3]);
    check_val("phase_a2", on & a_neg, seen[2]);
    check_val("phase_b1", on & ~b_neg, seen[1]);
    check_val("phase_b2", on & b_neg, seen[0]);
  endtask

  // Forward means A leads B
  task automatic enc_move(input logic fwd, input int count);
    repeat (count) begin
      enc_idx = fwd ? enc_idx + 2'd1 : enc_idx - 2'd1;
      @(posedge CLK);
      enc_a <= enc_idx[1] ^ enc_idx[0];
      enc_b <= enc_idx[1];
      wait_cycles(3);
    end
  endtask

  initial begin
    int n1, p1, n2, p2, n3, p3, k, j;
    logic d1;
    logic d2;
    resetn = 1'b0;
    sck    = 1'b0;
    cs     = 1'b1;
    copi   = 1'b0;
    enc_a  = 1'b0;
    enc_b  = 1'b0;
    n1 = 3 + lcg_range(8);
    p1 = 4 + lcg_range(12);
    d1 = lcg_range(2);
    n2 = 4 + lcg_range(4);
    p2 = 200 + lcg_range(40);  // Long enough to stay busy across a frame
    d2 = lcg_range(2);
    n3 = 2 + lcg_range(6);
    p3 = 3 + lcg_range(6);
    k  = 5 + lcg_range(20);
    j  = 1 + lcg_range(10);
    watchdog_cycles = n1 * p1 + n2 * p2 + n3 * p3 + 8 * 20 + 20 * 540 + 10 * 520
                      + (k + j + 2) * 4 + 5000;
    wait_cycles(4);
    resetn <= 1'b1;
    wait_cycles(2);

    @(negedge CLK);
    check_val("cipo", 0, cipo);
    check_val("step", 0, step);
    check_val("move_done", 0, move_done);
    check_val("phases", 0, {phase_a1, phase_a2, phase_b1, phase_b2});
    spi_frame(64'd0, rx);
    check_val("enc_count", 0, $signed(rx[63:32]));
    check_val("enc_fault", 0, rx[31]);
    check_val("move_busy", 0, rx[30]);

    run_move(d1, n1, p1);
    run_move(d1, 0, p1);  // Empty move gives only move_done

    // Second move lands while the first runs
    start_tracking(d2, p2);
    spi_frame(move_word(d2, n2, p2), rx);
    spi_frame(move_word(~d2, n3, p3), rx);
    check_val("move_busy", 1, rx[30]);
    wait_done(n2 * p2 + 100);
    wait_cycles(n3 * p3 + 20);
    check_val("step count", n2, step_total);
    check_val("move_done count", 1, done_total);

    start_tracking(d1, p3);
    spi_frame({8'h7f, 1'b1, 7'd0, 24'd3, 24'd4}, rx);
    wait_cycles(100);
    check_val("step count", 0, step_total);
    check_val("move_done count", 0, done_total);

    spi_frame(cfg_word(rapcore_pkg::reg_current, 32'd255), rx);
    spi_frame(cfg_word(rapcore_pkg::reg_microsteps, 32'd2), rx);
    exp_shift = 2;  // 64 positions per step
    spi_frame(cfg_word(rapcore_pkg::reg_enable, 32'd1), rx);
    check_phases(1'b1);
    repeat (4) begin
      run_move(1'b1, 1, 4);
      check_phases(1'b1);
    end
    repeat (4) begin
      run_move(1'b0, 1, 4);
      check_phases(1'b1);
    end
    spi_frame(cfg_word(rapcore_pkg::reg_enable, 32'd0), rx);
    check_phases(1'b0);

    enc_move(1'b1, k);
    enc_move(1'b0, j);
    spi_frame(64'd0, rx);
    check_val("enc_count", k - j, $signed(rx[63:32]));
    check_val("enc_fault", 0, rx[31]);
    enc_idx = enc_idx + 2'd2;  // Both lines flip at once
    @(posedge CLK);
    enc_a <= ~enc_a;
    enc_b <= ~enc_b;
    wait_cycles(8);
    spi_frame(64'd0, rx);
    check_val("enc_fault", 1, rx[31]);
    check_val("enc_count", k - j, $signed(rx[63:32]));

    wait_cycles(10);
    $display("Value errors: %0d, assertion errors: %0d", errors, dut.checks.assert_errors);
    if (errors == 0 && dut.checks.assert_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge CLK);
    $display("Watchdog expired at %0t before all tests completed", $time);
    $display("Value errors: %0d, assertion errors: %0d", errors, dut.checks.assert_errors);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
rtl/rapcore_pkg.sv
rtl/spi_command_fsm.sv
rtl/step_pulse_gen.sv
rtl/phase_driver.sv
rtl/quad_encoder.sv
rtl/rapcore.sv
test/rapcore_chk.sv
test/rapcore_tb.sv

// File: Bender.yml
package:
  name: rapcore

sources:
  - files:
      - rtl/rapcore_pkg.sv
      - rtl/spi_command_fsm.sv
      - rtl/step_pulse_gen.sv
      - rtl/phase_driver.sv
      - rtl/quad_encoder.sv
      - rtl/rapcore.sv
  - target: test
    files:
      - test/rapcore_chk.sv
      - test/rapcore_tb.sv
